// ==== lms_weight.f ====
verilog/lms_pkg.sv
verilog/weight_mem.sv
verilog/mem_arbiter.sv
verilog/weight_updater.sv
verilog/weight_reader.sv
verilog/lms_weight_top.sv
test/lms_weight_chk.sv
test/lms_weight_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lms weight store testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lms_weight_tb -f lms_weight.f -o lms_weight_sim

./obj_dir/lms_weight_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

// ==== test/lms_weight_tb.sv ====
`default_nettype none

module lms_weight_tb
    import lms_pkg::*;
();

    localparam int num_taps = default_num_taps;
    localparam int err_w    = default_err_w;
    localparam int reff_w   = default_reff_w;
    localparam int weight_w = default_weight_w;
    localparam int addr_w   = $clog2(num_taps);
    localparam int max_updates  = 90;           // all tests together
    localparam int cyc_per_tap  = 6;            // rmw plus contention and handshake
    localparam int max_reads    = 150;
    localparam int cyc_per_read = 8;
    localparam int watchdog_cycles =
        2 * (max_updates * num_taps * cyc_per_tap + max_reads * cyc_per_read);

    logic                       clk;
    logic                       rstn;
    logic                       upd_req;
    logic [err_w-1:0]           err;
    logic [num_taps*reff_w-1:0] reff_flat;
    logic                       upd_ack;
    logic                       rd_req;
    logic [addr_w-1:0]          rd_addr;
    logic                       rd_ack;
    logic [weight_w-1:0]        rd_data;

    logic [weight_w-1:0] model [num_taps];      // expected weights
    logic [reff_w-1:0]   reff_v [num_taps];     // samples for the next update
    int                  checks;
    int                  errors;
    logic                upd_ack_q;             // previous ack levels
    logic                rd_ack_q;

    lms_weight_top #(
        .num_taps (num_taps),
        .err_w    (err_w),
        .reff_w   (reff_w),
        .weight_w (weight_w)
    ) uut (
        .clk       (clk),
        .rstn      (rstn),
        .upd_req   (upd_req),
        .err       (err),
        .reff_flat (reff_flat),
        .upd_ack   (upd_ack),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // period 100
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

    // an ack may only rise while its req is up
    always @(negedge clk)
    begin
        if (rstn && upd_ack && !upd_ack_q && !upd_req)
        begin
            errors++;
            $display("upd_ack rose with no update request pending");
        end
        if (rstn && rd_ack && !rd_ack_q && !rd_req)
        begin
            errors++;
            $display("rd_ack rose with no read request pending");
        end
        upd_ack_q = upd_ack;
        rd_ack_q  = rd_ack;
    end

    // lms rule: old + err * reff, unsigned, wraps at weight_w
    function automatic logic [weight_w-1:0] next_weight(input logic [weight_w-1:0] old,
                                                        input logic [err_w-1:0] e,
                                                        input logic [reff_w-1:0] r);
        longint sum;
        sum = longint'(old) + longint'(e) * longint'(r);
        return sum[weight_w-1:0];
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic do_update(input logic [err_w-1:0] e);
        @(posedge clk);
        err <= e;
        for (int k = 0; k < num_taps; k++)
            reff_flat[k*reff_w +: reff_w] <= reff_v[k];
        upd_req <= 1'b1;
        @(negedge clk);
        while (!upd_ack)
            @(negedge clk);                     // all taps written
        for (int k = 0; k < num_taps; k++)
            model[k] = next_weight(model[k], e, reff_v[k]);
        @(posedge clk);
        upd_req <= 1'b0;
        @(negedge clk);
        if (!upd_ack)
        begin
            errors++;
            $display("upd_ack fell before upd_req was released");
        end
        while (upd_ack)
            @(negedge clk);
    endtask

    task automatic do_read(input int a, output logic [weight_w-1:0] d);
        @(posedge clk);
        rd_addr <= addr_w'(a);
        rd_req  <= 1'b1;
        @(negedge clk);
        while (!rd_ack)
            @(negedge clk);
        d = rd_data;                            // stable while ack high
        @(posedge clk);
        rd_req <= 1'b0;
        @(negedge clk);
        if (!rd_ack)
        begin
            errors++;
            $display("rd_ack fell before rd_req was released");
        end
        while (rd_ack)
            @(negedge clk);
    endtask

    task automatic check_all_taps(input string name);
        logic [weight_w-1:0] d;
        for (int k = 0; k < num_taps; k++)
        begin
            do_read(k, d);
            check(name, model[k], d);
        end
    endtask

    task automatic set_reff_random();
        for (int k = 0; k < num_taps; k++)
            reff_v[k] = reff_w'($urandom);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("reset upd_ack", 32'd0, upd_ack);
        check("reset rd_ack", 32'd0, rd_ack);
        check_all_taps("reset weights");        // all zero
    endtask

    task automatic test_single();
        for (int k = 0; k < num_taps; k++)
            reff_v[k] = reff_w'(k * 1000 + 37); // distinct per tap
        do_update(err_w'(1234));
        check_all_taps("single update");
    endtask

    task automatic test_random();
        repeat (10)
        begin
            set_reff_random();
            do_update(err_w'($urandom));
        end
        check_all_taps("random accumulate");
    endtask

    task automatic test_wrap();
        for (int k = 0; k < num_taps; k++)
            reff_v[k] = '1;
        repeat (70)
            do_update('1);                      // about 64 max products per wrap
        check_all_taps("weight wrap");
    endtask

    task automatic test_concurrent();
        logic [weight_w-1:0] old_w [num_taps];
        logic [weight_w-1:0] new_w [num_taps];
        logic [weight_w-1:0] d;
        logic [err_w-1:0]    e;
        int                  a;
        repeat (3)
        begin
            set_reff_random();
            e = err_w'($urandom);
            for (int k = 0; k < num_taps; k++)
            begin
                old_w[k] = model[k];
                new_w[k] = next_weight(model[k], e, reff_v[k]);
            end
            fork
                do_update(e);
                begin
                    repeat (2) @(posedge clk);  // let the update get going
                    repeat (6)
                    begin
                        a = $urandom_range(num_taps - 1, 0);
                        do_read(a, d);
                        if (d === new_w[a])
                            check("read during update", new_w[a], d);
                        else
                            check("read during update", old_w[a], d);
                    end
                end
            join
        end
        check_all_taps("after contention");
    endtask

    task automatic test_back_to_back();
        set_reff_random();
        do_update(err_w'($urandom));
        set_reff_random();
        do_update(err_w'($urandom));            // issued right after the first
        check_all_taps("back to back");
    endtask

    initial
    begin
        void'($urandom(32'h43953ec9));          // one seed for the whole run
        rstn      = 1'b0;
        upd_req   = 1'b0;
        err       = '0;
        reff_flat = '0;
        rd_req    = 1'b0;
        rd_addr   = '0;
        checks    = 0;
        errors    = 0;
        upd_ack_q = 1'b0;
        rd_ack_q  = 1'b0;
        for (int k = 0; k < num_taps; k++)
            model[k] = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        test_single();
        test_random();
        test_wrap();
        test_concurrent();
        test_back_to_back();
        errors = errors + uut.u_arbiter.arb_chk.fail_count;
        $display("checks %0d, errors %0d, of which assertion failures %0d",
                 checks, errors, uut.u_arbiter.arb_chk.fail_count);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/lms_weight_chk.sv ====
`default_nettype none

module lms_weight_chk
(
    input wire     clk,
    input wire     rstn,
    input wire     upd_mem_req,
    input wire     rdr_mem_req,
    input wire     upd_mem_gnt,
    input wire     rdr_mem_gnt
);

    int   fail_count = 0;                       // read by the testbench at the end
    logic both_req;

    assign both_req = upd_mem_req && rdr_mem_req;   // contention cycle

    // never two owners of the single port
    one_grant: assert property (@(posedge clk) disable iff (!rstn)
        !(upd_mem_gnt && rdr_mem_gnt))
    else
    begin
        $error("both clients granted in the same cycle");
        fail_count++;
    end

    // grant only to a client that asks
    upd_gnt_has_req: assert property (@(posedge clk) disable iff (!rstn)
        upd_mem_gnt |-> upd_mem_req)
    else
    begin
        $error("update engine granted without a request");
        fail_count++;
    end

    rdr_gnt_has_req: assert property (@(posedge clk) disable iff (!rstn)
        rdr_mem_gnt |-> rdr_mem_req)
    else
    begin
        $error("readback engine granted without a request");
        fail_count++;
    end

    // back-to-back contention flips the winner
    alternate: assert property (@(posedge clk) disable iff (!rstn)
        (both_req && $past(both_req)) |-> (upd_mem_gnt != $past(upd_mem_gnt)))
    else
    begin
        $error("grants did not alternate under contention");
        fail_count++;
    end

endmodule

bind mem_arbiter lms_weight_chk arb_chk
(
    .clk         (clk),
    .rstn        (rstn),
    .upd_mem_req (upd_mem_req),
    .rdr_mem_req (rdr_mem_req),
    .upd_mem_gnt (upd_mem_gnt),
    .rdr_mem_gnt (rdr_mem_gnt)
);

`default_nettype wire

// ==== verilog/lms_weight_top.sv ====
`default_nettype none

module lms_weight_top
    import lms_pkg::*;
#(
    parameter int num_taps = default_num_taps,
    parameter int err_w    = default_err_w,
    parameter int reff_w   = default_reff_w,
    parameter int weight_w = default_weight_w,
    localparam int addr_w  = $clog2(num_taps)
)
(
    input  wire                        clk,
    input  wire                        rstn,
    // update handshake
    input  wire                        upd_req,
    input  wire [err_w-1:0]            err,
    input  wire [num_taps*reff_w-1:0]  reff_flat,
    output logic                       upd_ack,
    // readback handshake
    input  wire                        rd_req,
    input  wire [addr_w-1:0]           rd_addr,
    output logic                       rd_ack,
    output logic [weight_w-1:0]        rd_data
);

    // update engine to arbiter
    logic                upd_mem_req;
    logic                upd_mem_we;
    logic [addr_w-1:0]   upd_mem_addr;
    logic [weight_w-1:0] upd_mem_wdata;
    logic                upd_mem_gnt;
    // readback engine to arbiter
    logic                rdr_mem_req;
    logic [addr_w-1:0]   rdr_mem_addr;
    logic                rdr_mem_gnt;
    // arbiter to memory
    logic                mem_en;
    logic                mem_we;
    logic [addr_w-1:0]   mem_addr;
    logic [weight_w-1:0] mem_wdata;
    logic [weight_w-1:0] mem_rdata;             // shared by both engines

    weight_updater #(
        .num_taps (num_taps),
        .err_w    (err_w),
        .reff_w   (reff_w),
        .weight_w (weight_w)
    ) u_updater (
        .clk       (clk),
        .rstn      (rstn),
        .upd_req   (upd_req),
        .err       (err),
        .reff_flat (reff_flat),
        .upd_ack   (upd_ack),
        .mem_req   (upd_mem_req),
        .mem_we    (upd_mem_we),
        .mem_addr  (upd_mem_addr),
        .mem_wdata (upd_mem_wdata),
        .mem_gnt   (upd_mem_gnt),
        .mem_rdata (mem_rdata)
    );

    weight_reader #(
        .num_taps (num_taps),
        .weight_w (weight_w)
    ) u_reader (
        .clk       (clk),
        .rstn      (rstn),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .mem_req   (rdr_mem_req),
        .mem_addr  (rdr_mem_addr),
        .mem_gnt   (rdr_mem_gnt),
        .mem_rdata (mem_rdata)
    );

    mem_arbiter #(
        .num_taps (num_taps),
        .weight_w (weight_w)
    ) u_arbiter (
        .clk           (clk),
        .rstn          (rstn),
        .upd_mem_req   (upd_mem_req),
        .upd_mem_we    (upd_mem_we),
        .upd_mem_addr  (upd_mem_addr),
        .upd_mem_wdata (upd_mem_wdata),
        .upd_mem_gnt   (upd_mem_gnt),
        .rdr_mem_req   (rdr_mem_req),
        .rdr_mem_addr  (rdr_mem_addr),
        .rdr_mem_gnt   (rdr_mem_gnt),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .last_gnt      ()
    );

    weight_mem #(
        .num_taps (num_taps),
        .weight_w (weight_w)
    ) u_mem (
        .clk   (clk),
        .rstn  (rstn),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .en    (mem_en),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== verilog/weight_reader.sv ====
`default_nettype none

module weight_reader
    import lms_pkg::*;
#(
    parameter int num_taps = default_num_taps,
    parameter int weight_w = default_weight_w,
    localparam int addr_w  = $clog2(num_taps)
)
(
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  rd_req,        // four-phase from host
    input  wire [addr_w-1:0]     rd_addr,       // held by host during req
    output logic                 rd_ack,
    output logic [weight_w-1:0]  rd_data,       // stable while rd_ack high
    output logic                 mem_req,
    output logic [addr_w-1:0]    mem_addr,
    input  wire                  mem_gnt,
    input  wire [weight_w-1:0]   mem_rdata
);

    typedef enum logic [1:0]
    {
        st_idle,
        st_req,                                 // waiting on arbiter
        st_wait,                                // data one cycle after grant
        st_ack
    } state_t;

    state_t state;

    assign mem_req  = (state == st_req);
    assign mem_addr = rd_addr;
    assign rd_ack   = (state == st_ack);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= st_idle;
        else
        begin
            case (state)
                st_idle:
                    if (rd_req)
                        state <= st_req;
                st_req:
                    if (mem_gnt)
                        state <= st_wait;
                st_wait:
                    state <= st_ack;
                st_ack:
                    if (!rd_req)
                        state <= st_idle;       // host done, release ack
                default:
                    state <= st_idle;
            endcase
        end
    end

    // capture on our own returning read only
    always_ff @(posedge clk)
    begin
        if (state == st_wait)
            rd_data <= mem_rdata;
    end

endmodule

`default_nettype wire

// ==== verilog/weight_updater.sv ====
`default_nettype none

module weight_updater
    import lms_pkg::*;
#(
    parameter int num_taps = default_num_taps,
    parameter int err_w    = default_err_w,
    parameter int reff_w   = default_reff_w,
    parameter int weight_w = default_weight_w,
    localparam int addr_w  = $clog2(num_taps),
    localparam int prod_w  = err_w + reff_w
)
(
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        upd_req,     // four-phase from host
    input  wire [err_w-1:0]            err,
    input  wire [num_taps*reff_w-1:0]  reff_flat,   // tap k at bits k*reff_w
    output logic                       upd_ack,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [addr_w-1:0]          mem_addr,
    output logic [weight_w-1:0]        mem_wdata,
    input  wire                        mem_gnt,
    input  wire [weight_w-1:0]         mem_rdata    // broadcast read data
);

    typedef enum logic [2:0]
    {
        st_idle,
        st_read,                                    // ask for old weight
        st_wait,                                    // read data returns
        st_write,                                   // write back new weight
        st_done                                     // ack held until req drops
    } state_t;

    state_t              state;
    logic [addr_w-1:0]   tap;                       // tap being updated
    logic [reff_w-1:0]   tap_reff;
    logic [prod_w-1:0]   product;                   // err * reff, unsigned
    logic [weight_w-1:0] new_weight;
    logic [weight_w-1:0] wr_data;                   // held through write grant

    assign tap_reff   = reff_flat[tap*reff_w +: reff_w];
    assign product    = err * tap_reff;
    assign new_weight = mem_rdata + weight_w'(product);  // wraps at weight_w

    assign mem_req   = (state == st_read) || (state == st_write);
    assign mem_we    = (state == st_write);
    assign mem_addr  = tap;
    assign mem_wdata = wr_data;
    assign upd_ack   = (state == st_done);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= st_idle;
            tap   <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (upd_req)
                    begin
                        tap   <= '0;                // start at tap 0
                        state <= st_read;
                    end
                st_read:
                    if (mem_gnt)
                        state <= st_wait;           // else hold the request
                st_wait:
                    state <= st_write;              // rdata is ours this cycle
                st_write:
                    if (mem_gnt)
                    begin
                        if (tap == addr_w'(num_taps - 1))
                            state <= st_done;
                        else
                        begin
                            tap   <= tap + 1'b1;
                            state <= st_read;
                        end
                    end
                st_done:
                    if (!upd_req)
                        state <= st_idle;           // drop ack after req
                default:
                    state <= st_idle;
            endcase
        end
    end

    // sum captured as the old weight returns
    always_ff @(posedge clk)
    begin
        if (state == st_wait)
            wr_data <= new_weight;
    end

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter
    import lms_pkg::*;
#(
    parameter int num_taps = default_num_taps,
    parameter int weight_w = default_weight_w,
    localparam int addr_w  = $clog2(num_taps)
)
(
    input  wire                  clk,
    input  wire                  rstn,
    // update engine, read-modify-write
    input  wire                  upd_mem_req,
    input  wire                  upd_mem_we,
    input  wire [addr_w-1:0]     upd_mem_addr,
    input  wire [weight_w-1:0]   upd_mem_wdata,
    output logic                 upd_mem_gnt,
    // readback engine, reads only
    input  wire                  rdr_mem_req,
    input  wire [addr_w-1:0]     rdr_mem_addr,
    output logic                 rdr_mem_gnt,
    // towards weight_mem
    output logic                 mem_en,
    output logic                 mem_we,
    output logic [addr_w-1:0]    mem_addr,
    output logic [weight_w-1:0]  mem_wdata,
    output client_t              last_gnt       // round-robin pointer
);

    // same-cycle grant, the other client wins a tie
    always_comb
    begin
        upd_mem_gnt = upd_mem_req && (!rdr_mem_req || last_gnt == client_read);
        rdr_mem_gnt = rdr_mem_req && (!upd_mem_req || last_gnt == client_update);
    end

    // memory side mux
    assign mem_en    = upd_mem_gnt || rdr_mem_gnt;
    assign mem_we    = upd_mem_gnt && upd_mem_we;             // reader never writes
    assign mem_addr  = rdr_mem_gnt ? rdr_mem_addr : upd_mem_addr;
    assign mem_wdata = upd_mem_wdata;                         // only used on update writes

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            last_gnt <= client_read;                          // updater first on a tie
        else if (upd_mem_gnt)
            last_gnt <= client_update;
        else if (rdr_mem_gnt)
            last_gnt <= client_read;
    end

endmodule

`default_nettype wire

// ==== verilog/weight_mem.sv ====
`default_nettype none

module weight_mem
    import lms_pkg::*;
#(
    parameter int num_taps = default_num_taps,
    parameter int weight_w = default_weight_w,
    localparam int addr_w  = $clog2(num_taps)
)
(
    input  wire                  clk,
    input  wire                  rstn,
    input  wire [addr_w-1:0]     addr,          // tap index
    input  wire                  we,            // write when set, else read
    input  wire [weight_w-1:0]   wdata,
    input  wire                  en,            // access strobe from arbiter
    output logic [weight_w-1:0]  rdata          // valid one cycle after read
);

    logic [weight_w-1:0] weights [num_taps];    // one entry per tap

    // single port, write or read per enabled cycle
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < num_taps; i++)
                weights[i] <= '0;               // filter starts from zero weights
            rdata <= '0;
        end
        else if (en)
        begin
            if (we)
                weights[addr] <= wdata;         // lands at the grant edge
            else
                rdata <= weights[addr];         // registered read
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lms_pkg.sv ====
`default_nettype none

package lms_pkg;

    // filter geometry
    localparam int default_num_taps = 16;       // taps in the filter
    localparam int default_err_w    = 11;       // error sample width
    localparam int default_reff_w   = 14;       // reference sample width
    localparam int default_weight_w = 31;       // accumulated weight, wraps

    // who owns the weight memory in a given cycle
    typedef enum logic
    {
        client_update = 1'b0,                   // lms update engine
        client_read   = 1'b1                    // host readback engine
    } client_t;

endpackage

`default_nettype wire
